// File: src.f
+incdir+include
rtl/fpu_pkg.sv
rtl/pipe_ctrl.sv
rtl/float_mul.sv
rtl/recip_table.sv
rtl/float_recip.sv
rtl/fpu_unit.sv
dv/fpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the FPU testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary -f src.f --top-module fpu_tb -o fpu_tb_sim &&
./obj_dir/fpu_tb_sim || { echo "simulation failed"; exit 1; }

// File: dv/fpu_tb.sv
// -------------------------------------------------------------------------
// FPU unit testbench
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "fpu_defines.svh"

module fpu_tb;

	logic              clk;
	logic              rst_n;
	fpu_pkg::fpu_req_t req;
	logic              req_valid;
	logic              req_ready;
	fpu_pkg::fpu_rsp_t rsp;
	logic              rsp_valid;
	logic              rsp_ready;

	logic [31:0]       lfsr;
	// requests in flight, oldest first
	fpu_pkg::fpu_req_t sb [$];

	fpu_unit dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready)
	);

	always #5 clk = ~clk;

	// -------------------------------------------------------------------------
	// stimulus and reference helpers
	// -------------------------------------------------------------------------

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// exponent kept within 64..190
	function automatic fpu_pkg::float_t make_operand();
		fpu_pkg::float_t f;
		logic [31:0]     r;
		r = rand_bits(1);
		f.sign = r[0];
		r = rand_bits(7);
		f.exp = 8'(64 + r % 127);
		r = rand_bits(`FPU_FRAC_W);
		f.frac = r[`FPU_FRAC_W-1:0];
		return f;
	endfunction

	function automatic fpu_pkg::float_t mul_model(input fpu_pkg::float_t a,
			input fpu_pkg::float_t b);
		fpu_pkg::float_t r;
		logic [47:0]     p;
		logic [24:0]     m;
		int              e;
		p = {24'd0, a.exp != 8'd0, a.frac} * {24'd0, b.exp != 8'd0, b.frac};
		m = p[47:23];
		e = int'(a.exp) + int'(b.exp) - `FPU_BIAS;
		r.sign = a.sign ^ b.sign;
		if (e < 0 || e > 255 || m < 25'h800000) begin
			r.exp = '0;
			r.frac = '0;
		end else if (m[24]) begin
			r.exp = 8'(e + 1);
			r.frac = m[23:1];
		end else begin
			r.exp = 8'(e);
			r.frac = m[22:0];
		end
		return r;
	endfunction

	// magnitude only, normal numbers
	function automatic real as_real(input fpu_pkg::float_t f);
		logic [10:0] e11;
		e11 = 11'(f.exp) + 11'd896;
		return $bitstoreal({1'b0, e11, f.frac, 29'd0});
	endfunction

	task automatic fail_run();
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic recip_within_tol(input fpu_pkg::float_t op, input fpu_pkg::float_t got);
		real err;
		check_eq("rsp.result.sign", 64'(got.sign), 64'(op.sign));
		err = as_real(got) * as_real(op) - 1.0;
		if (err < 0.0) begin
			err = -err;
		end
		if (err > 1.0 / 4096.0) begin
			$display("Mismatch rsp.result: got %h for operand %h, error above 2^-12", got, op);
			fail_run();
		end
	endtask

	task automatic compare_response(input fpu_pkg::fpu_req_t r, input fpu_pkg::fpu_rsp_t got);
		check_eq("rsp.tag", 64'(got.tag), 64'(r.tag));
		if (r.op == fpu_pkg::OP_MUL) begin
			check_eq("rsp.result", 64'(got.result), 64'(mul_model(r.a, r.b)));
		end else begin
			recip_within_tol(r.a, got.result);
		end
	endtask

	// -------------------------------------------------------------------------
	// directed tests
	// -------------------------------------------------------------------------

	// lone request into an empty pipe, result due 4 edges after acceptance
	task automatic single_request(input fpu_pkg::fpu_op_e op, input logic [7:0] tag,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp_result);
		int cycles;
		cycles = 0;
		@(negedge clk);
		req.op = op;
		req.tag = tag;
		req.a = a;
		req.b = b;
		req_valid = 1'b1;
		rsp_ready = 1'b1;
		#1;
		while (!req_ready) begin
			@(negedge clk);
			#1;
			cycles++;
			if (cycles > 200) begin
				$display("timeout while waiting for req_ready");
				fail_run();
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
		cycles = 0;
		while (!rsp_valid) begin
			@(negedge clk);
			cycles++;
			if (cycles > 200) begin
				$display("timeout while waiting for rsp_valid");
				fail_run();
			end
		end
		check_eq("latency", 64'(cycles), 64'd4);
		check_eq("rsp.tag", 64'(rsp.tag), 64'(tag));
		check_eq("rsp.result", 64'(rsp.result), 64'(exp_result));
	endtask

	task automatic reset_state();
		check_eq("rsp_valid", 64'(rsp_valid), 64'd0);
		check_eq("req_ready", 64'(req_ready), 64'd1);
		check_eq("stage_valid", 64'(dut0.stage_valid), 64'd0);
	endtask

	task automatic known_products();
		single_request(fpu_pkg::OP_MUL, 8'h11, 32'h3fc00000, 32'hc0000000, 32'hc0400000);
		single_request(fpu_pkg::OP_MUL, 8'h22, 32'h40400000, 32'h3e800000, 32'h3f400000);
		// 1.5 * 1.5 needs the normalize shift
		single_request(fpu_pkg::OP_MUL, 8'h33, 32'h3fc00000, 32'h3fc00000, 32'h40100000);
	endtask

	task automatic exact_reciprocals();
		single_request(fpu_pkg::OP_RECIP, 8'h41, 32'h40000000, 32'h0, 32'h3f000000);
		single_request(fpu_pkg::OP_RECIP, 8'h42, 32'h3f800000, 32'h0, 32'h3f800000);
		single_request(fpu_pkg::OP_RECIP, 8'h43, 32'hbe800000, 32'h0, 32'hc0800000);
		// zero exponent gives all ones exponent
		single_request(fpu_pkg::OP_RECIP, 8'h44, 32'h00000000, 32'h0, 32'h7f800000);
		single_request(fpu_pkg::OP_RECIP, 8'h45, 32'h80000000, 32'h0, 32'hff800000);
	endtask

	// mode 0 multiply, 1 reciprocal, 2 mixed
	task automatic stream_requests(input int n, input int mode, input bit bp);
		fpu_pkg::fpu_req_t r;
		logic [31:0]       bits;
		int                sent;
		int                recv;
		int                idle;
		bit                took;
		sent = 0;
		recv = 0;
		idle = 0;
		took = 1'b0;
		while (recv < n) begin
			@(negedge clk);
			if (took) begin
				req_valid = 1'b0;
			end
			if (!req_valid && sent < n) begin
				bits = rand_bits(1);
				r.op = (mode == 1) ? fpu_pkg::OP_RECIP : fpu_pkg::OP_MUL;
				if (mode == 2) begin
					r.op = fpu_pkg::fpu_op_e'(bits[0]);
				end
				r.tag = 8'(sent);
				r.a = make_operand();
				r.b = make_operand();
				req = r;
				req_valid = 1'b1;
			end
			bits = rand_bits(1);
			rsp_ready = bp ? bits[0] : 1'b1;
			#1;
			took = req_valid && req_ready;
			if (took) begin
				sb.push_back(req);
				sent++;
			end
			if (rsp_valid && rsp_ready) begin
				if (sb.size() == 0) begin
					$display("response arrived with no request outstanding");
					fail_run();
				end
				compare_response(sb.pop_front(), rsp);
				recv++;
				idle = 0;
			end else begin
				idle++;
				if (idle > 200) begin
					$display("timeout while waiting for a response");
					fail_run();
				end
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
		rsp_ready = 1'b1;
		// nothing may follow the last result
		repeat (6) begin
			@(negedge clk);
			check_eq("rsp_valid", 64'(rsp_valid), 64'd0);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		lfsr = 32'h4ac1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_state();
		known_products();
		exact_reciprocals();
		stream_requests(200, 0, 1'b0);
		stream_requests(200, 1, 1'b0);
		stream_requests(200, 2, 1'b1);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: rtl/fpu_unit.sv
// -------------------------------------------------------------------------
// FPU top level
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "fpu_defines.svh"

module fpu_unit (
	input  logic              clk,
	input  logic              rst_n,

	input  fpu_pkg::fpu_req_t req,
	input  logic              req_valid,
	output logic              req_ready,

	output fpu_pkg::fpu_rsp_t rsp,
	output logic              rsp_valid,
	input  logic              rsp_ready
);

	localparam int stages = `FPU_STAGES;

	// op and tag travelling beside the datapaths
	typedef struct packed {
		fpu_pkg::fpu_op_e      op;
		logic [`FPU_TAG_W-1:0] tag;
	} line_t;

	logic [stages-1:0] stage_en;
	logic [stages-1:0] stage_valid;
	logic [stages-1:0] line_en;
	logic              out_load;

	line_t             line_q [stages];
	fpu_pkg::float_t   mul_res;
	fpu_pkg::float_t   recip_res;
	fpu_pkg::fpu_rsp_t rsp_d;
	fpu_pkg::fpu_rsp_t rsp_q;

	pipe_ctrl #(
		.stages (stages)
	) u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_valid     (req_valid),
		.s_ready     (req_ready),
		.m_valid     (rsp_valid),
		.m_ready     (rsp_ready),
		.stage_en    (stage_en),
		.stage_valid (stage_valid),
		.out_load    (out_load)
	);

	float_mul u_mul (
		.clk      (clk),
		.stage_en (stage_en),
		.a        (req.a),
		.b        (req.b),
		.result   (mul_res)
	);

	float_recip u_recip (
		.clk      (clk),
		.stage_en (stage_en),
		.a        (req.a),
		.result   (recip_res)
	);

	// -------------------------------------------------------------------------
	// op and tag line, moved only when a valid entry arrives
	// -------------------------------------------------------------------------
	assign line_en = stage_en & {stage_valid[stages-2:0], req_valid};

	always_ff @(posedge clk) begin
		if (line_en[0]) begin
			line_q[0] <= '{op: req.op, tag: req.tag};
		end
		for (int i = 1; i < stages; i++) begin
			if (line_en[i]) begin
				line_q[i] <= line_q[i-1];
			end
		end
	end

	// result select by the op leaving stage 3
	assign rsp_d.tag    = line_q[stages-1].tag;
	assign rsp_d.result = (line_q[stages-1].op == fpu_pkg::OP_RECIP) ? recip_res : mul_res;

	// skid register
	always_ff @(posedge clk) begin
		if (out_load) begin
			rsp_q <= rsp_d;
		end
	end

	assign rsp = rsp_q;

endmodule

// File: rtl/float_recip.sv
// -------------------------------------------------------------------------
// binary32 reciprocal, table plus linear interpolation
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "fpu_defines.svh"

module float_recip (
	input  logic            clk,
	input  logic [3:0]      stage_en,
	input  fpu_pkg::float_t a,
	output fpu_pkg::float_t result
);

	localparam int exp_w = `FPU_EXP_W;
	localparam int frac_w = `FPU_FRAC_W;
	localparam int bias = `FPU_BIAS;
	localparam int d_w = `FPU_TBL_D_W;
	localparam int lo_w = frac_w - d_w;

	logic              s0_sign;
	logic [exp_w-1:0]  s0_exp;
	logic              s0_fzero;
	logic [lo_w-1:0]   s0_low;

	logic              s1_sign;
	logic [exp_w-1:0]  s1_exp;
	logic              s1_fzero;
	logic [lo_w-1:0]   s1_low;

	logic              s2_sign;
	logic [exp_w-1:0]  s2_exp;
	logic              s2_fzero;
	logic [frac_w-1:0] s2_frac;

	fpu_pkg::float_t   s3_res;

	logic [frac_w-1:0]      tbl_base;
	logic [frac_w-1:0]      tbl_grad;
	logic [frac_w+lo_w-1:0] corr;
	logic [exp_w:0]         exp_base;
	logic [exp_w:0]         exp_diff;

	// table lookup spans stages 0 and 1
	recip_table u_table (
		.clk  (clk),
		.en   (stage_en[1:0]),
		.idx  (a.frac[frac_w-1 -: d_w]),
		.base (tbl_base),
		.grad (tbl_grad)
	);

	always_ff @(posedge clk) begin
		if (stage_en[0]) begin
			s0_sign  <= a.sign;
			s0_exp   <= a.exp;
			s0_fzero <= a.frac == '0;
			s0_low   <= a.frac[lo_w-1:0];
		end
		if (stage_en[1]) begin
			s1_sign  <= s0_sign;
			s1_exp   <= s0_exp;
			s1_fzero <= s0_fzero;
			s1_low   <= s0_low;
		end
	end

	// interpolate within the segment
	assign corr = tbl_grad * s1_low;

	always_ff @(posedge clk) begin
		if (stage_en[2]) begin
			s2_sign  <= s1_sign;
			s2_exp   <= s1_exp;
			s2_fzero <= s1_fzero;
			s2_frac  <= tbl_base - corr[frac_w+lo_w-1:lo_w];
		end
	end

	// 2/m lies in (1, 2] so the exponent drops by one more unless m is 1
	assign exp_base = s2_fzero ? (exp_w + 1)'(2 * bias) : (exp_w + 1)'(2 * bias - 1);
	assign exp_diff = exp_base - {1'b0, s2_exp};

	always_ff @(posedge clk) begin
		if (stage_en[3]) begin
			s3_res.sign <= s2_sign;
			if (s2_exp == '0) begin
				s3_res.exp  <= '1;
				s3_res.frac <= '0;
			end else if (exp_diff[exp_w] || exp_diff == '0) begin
				s3_res.exp  <= '0;
				s3_res.frac <= '0;
			end else begin
				s3_res.exp  <= exp_diff[exp_w-1:0];
				s3_res.frac <= s2_frac;
			end
		end
	end

	assign result = s3_res;

endmodule

// File: rtl/recip_table.sv
// -------------------------------------------------------------------------
// Reciprocal base and gradient table
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "fpu_defines.svh"

module recip_table (
	input  logic                     clk,
	input  logic [1:0]               en,
	input  logic [`FPU_TBL_D_W-1:0]  idx,
	output logic [`FPU_FRAC_W-1:0]   base,
	output logic [`FPU_FRAC_W-1:0]   grad
);

	localparam int frac_w = `FPU_FRAC_W;
	localparam int d_w = `FPU_TBL_D_W;
	localparam int depth = 1 << d_w;

	// entry i holds 2/x at x = 1 + i/64 and the drop to the next segment
	function automatic logic [depth-1:0][2*frac_w-1:0] build_table();
		logic [depth-1:0][2*frac_w-1:0] tbl;
		logic [2*frac_w+1:0]            num;
		logic [2*frac_w+1:0]            seg;
		logic [2*frac_w+1:0]            step;
		logic [2*frac_w+1:0]            cur;
		logic [2*frac_w+1:0]            nxt;
		num = '0;
		num[2*frac_w+1] = 1'b1;
		seg = '0;
		seg[frac_w] = 1'b1;
		step = '0;
		step[frac_w-d_w] = 1'b1;
		for (int i = 0; i < depth; i++) begin
			cur = num / seg;
			nxt = num / (seg + step);
			tbl[i] = {cur[frac_w-1:0], frac_w'(cur - nxt)};
			seg = seg + step;
		end
		return tbl;
	endfunction

	localparam logic [depth-1:0][2*frac_w-1:0] table_rom = build_table();

	logic [2*frac_w-1:0] rd_q;
	logic [2*frac_w-1:0] out_q;

	always_ff @(posedge clk) begin
		if (en[0]) begin
			rd_q <= table_rom[idx];
		end
		if (en[1]) begin
			out_q <= rd_q;
		end
	end

	assign base = out_q[2*frac_w-1:frac_w];
	assign grad = out_q[frac_w-1:0];

endmodule

// File: rtl/float_mul.sv
// -------------------------------------------------------------------------
// binary32 multiply, four stages, truncating
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "fpu_defines.svh"

module float_mul (
	input  logic            clk,
	input  logic [3:0]      stage_en,
	input  fpu_pkg::float_t a,
	input  fpu_pkg::float_t b,
	output fpu_pkg::float_t result
);

	localparam int exp_w = `FPU_EXP_W;
	localparam int frac_w = `FPU_FRAC_W;
	localparam int bias = `FPU_BIAS;

	// stage 0
	logic              s0_sign_a;
	logic              s0_sign_b;
	logic [exp_w-1:0]  s0_exp_a;
	logic [exp_w-1:0]  s0_exp_b;
	logic [frac_w:0]   s0_man_a;
	logic [frac_w:0]   s0_man_b;

	// stages 1 and 2
	logic              s1_sign;
	logic [exp_w:0]    s1_exp;
	logic [frac_w+1:0] s1_man;
	logic              s2_sign;
	logic [exp_w:0]    s2_exp;
	logic [frac_w+1:0] s2_man;

	fpu_pkg::float_t   s3_res;

	logic [2*frac_w+1:0] prod;
	logic [exp_w:0]      exp_sum;

	always_ff @(posedge clk) begin
		if (stage_en[0]) begin
			s0_sign_a <= a.sign;
			s0_sign_b <= b.sign;
			s0_exp_a  <= a.exp;
			s0_exp_b  <= b.exp;
			// hidden bit is zero for a zero exponent
			s0_man_a  <= {a.exp != '0, a.frac};
			s0_man_b  <= {b.exp != '0, b.frac};
		end
	end

	assign prod    = s0_man_a * s0_man_b;
	assign exp_sum = {1'b0, s0_exp_a} + {1'b0, s0_exp_b} - (exp_w + 1)'(bias);

	always_ff @(posedge clk) begin
		if (stage_en[1]) begin
			s1_sign <= s0_sign_a ^ s0_sign_b;
			s1_exp  <= exp_sum;
			s1_man  <= prod[2*frac_w+1:frac_w];
		end
	end

	always_ff @(posedge clk) begin
		if (stage_en[2]) begin
			s2_sign <= s1_sign;
			s2_exp  <= s1_exp;
			s2_man  <= s1_man;
		end
	end

	// -------------------------------------------------------------------------
	// normalize and truncate
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (stage_en[3]) begin
			s3_res.sign <= s2_sign;
			if (s2_exp[exp_w] || s2_man[frac_w+1:frac_w] == 2'b00) begin
				// out of range or product below 1
				s3_res.exp  <= '0;
				s3_res.frac <= '0;
			end else if (s2_man[frac_w+1]) begin
				s3_res.exp  <= s2_exp[exp_w-1:0] + 1'b1;
				s3_res.frac <= s2_man[frac_w:1];
			end else begin
				s3_res.exp  <= s2_exp[exp_w-1:0];
				s3_res.frac <= s2_man[frac_w-1:0];
			end
		end
	end

	assign result = s3_res;

endmodule

// File: rtl/pipe_ctrl.sv
// -------------------------------------------------------------------------
// Stall pipeline controller with output skid slot
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "fpu_defines.svh"

module pipe_ctrl #(
	parameter int stages = `FPU_STAGES
) (
	input  logic              clk,
	input  logic              rst_n,

	input  logic              s_valid,
	output logic              s_ready,

	output logic              m_valid,
	input  logic              m_ready,

	output logic [stages-1:0] stage_en,
	output logic [stages-1:0] stage_valid,
	output logic              out_load
);

	logic [stages-1:0] valid_q;
	logic              out_full;
	logic              slot_free;

	// skid slot can take a new word when empty or being read this cycle
	assign slot_free = !out_full || m_ready;

	// -------------------------------------------------------------------------
	// stall chain, walked from the output back to the input
	// -------------------------------------------------------------------------
	always_comb begin
		stage_en[stages-1] = !valid_q[stages-1] || slot_free;
		for (int i = stages - 2; i >= 0; i--) begin
			stage_en[i] = !valid_q[i] || stage_en[i+1];
		end
	end

	assign out_load = valid_q[stages-1] && slot_free;

	// -------------------------------------------------------------------------
	// valid bits
	// -------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			if (stage_en[0]) begin
				valid_q[0] <= s_valid;
			end
			for (int i = 1; i < stages; i++) begin
				// upstream always moves when this stage takes a word
				if (stage_en[i]) begin
					valid_q[i] <= valid_q[i-1];
				end
			end
		end
	end

	// output slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_full <= 1'b0;
		end else if (out_load) begin
			out_full <= 1'b1;
		end else if (m_ready) begin
			out_full <= 1'b0;
		end
	end

	assign s_ready     = stage_en[0];
	assign m_valid     = out_full;
	assign stage_valid = valid_q;

endmodule

// File: rtl/fpu_pkg.sv
// -------------------------------------------------------------------------
// FPU shared types
// -------------------------------------------------------------------------

`include "fpu_defines.svh"

package fpu_pkg;

	typedef enum logic {
		OP_MUL   = 1'b0,
		OP_RECIP = 1'b1
	} fpu_op_e;

	// one binary32 word
	typedef struct packed {
		logic                   sign;
		logic [`FPU_EXP_W-1:0]  exp;
		logic [`FPU_FRAC_W-1:0] frac;
	} float_t;

	// request, 73 bits
	typedef struct packed {
		fpu_op_e               op;
		logic [`FPU_TAG_W-1:0] tag;
		float_t                a;
		float_t                b;
	} fpu_req_t;

	// response, 40 bits
	typedef struct packed {
		logic [`FPU_TAG_W-1:0] tag;
		float_t                result;
	} fpu_rsp_t;

endpackage

// File: include/fpu_defines.svh
// -------------------------------------------------------------------------
// FPU widths and constants
// -------------------------------------------------------------------------

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// binary32 layout
`define FPU_EXP_W   8
`define FPU_FRAC_W  23
`define FPU_BIAS    127

// fraction bits that index the reciprocal table
`define FPU_TBL_D_W 6

`define FPU_TAG_W   8

// datapath depth
`define FPU_STAGES  4

`endif
